//--- design/flacPkg.sv
package flacPkg;

    // job setup, latched at start.
    typedef struct packed {
        logic [15:0] blockSize;
        logic [3:0]  predictorOrder;
        logic [3:0]  partitionOrder;
        logic [4:0]  startBit;    // bit offset from the word msb.
        logic [15:0] startAddr;
    } streamCfgT;

    // one parsed rice sample.
    typedef struct packed {
        logic [15:0] quotient;
        logic [15:0] remainder;
        logic [3:0]  param;
    } riceFieldT;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] value;
    } residualT;

    typedef enum logic [2:0] {
        idle,
        prime,
        param,
        samples,
        finish,
        fault
    } ctrlStateT;

    localparam logic [3:0] ESCAPE_PARAM = 4'd15;    // verbatim partition, unsupported.

endpackage

//--- design/apbPkg.sv
package apbPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    typedef enum logic [7:0] {
        ctrl      = 8'h00,
        status    = 8'h04,
        blockSize = 8'h08,
        orders    = 8'h0C,    // predictor [3:0], partition [7:4].
        startBit  = 8'h10,
        startAddr = 8'h14,
        count     = 8'h18
    } regAddrT;

endpackage

//--- design/residualApbRegs.sv
`timescale 1ns/1ps

module residualApbRegs (
    input  logic               iClock,
    input  logic               rstN,
    input  apbPkg::apbReqT     apbReq,
    output apbPkg::apbRspT     apbRsp,
    output flacPkg::streamCfgT cfg,
    output logic               start,
    input  logic               busy,
    input  logic               done,
    input  logic               error,
    input  logic [15:0]        sampleCount
);

    flacPkg::streamCfgT shadow;
    logic               access;
    logic               mapped;
    logic               readOnly;
    logic               launch;
    logic [31:0]        readData;

    assign access = apbReq.psel && apbReq.penable;
    assign launch = access && apbReq.pwrite && (apbReq.paddr == apbPkg::ctrl) &&
                    apbReq.pwdata[0] && !busy;    // ignored while a job runs.

    always_comb begin
        mapped   = 1'b1;
        readOnly = 1'b0;
        readData = '0;
        case (apbReq.paddr)
            apbPkg::ctrl: begin
                readData = {31'b0, busy};
            end
            apbPkg::status: begin
                readData = {29'b0, error, done, busy};
                readOnly = 1'b1;
            end
            apbPkg::blockSize: begin
                readData = {16'b0, shadow.blockSize};
            end
            apbPkg::orders: begin
                readData = {24'b0, shadow.partitionOrder, shadow.predictorOrder};
            end
            apbPkg::startBit: begin
                readData = {27'b0, shadow.startBit};
            end
            apbPkg::startAddr: begin
                readData = {16'b0, shadow.startAddr};
            end
            apbPkg::count: begin
                readData = {16'b0, sampleCount};
                readOnly = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign apbRsp.prdata  = readData;
    assign apbRsp.pready  = 1'b1;    // no wait states.
    assign apbRsp.pslverr = access && (!mapped || (apbReq.pwrite && readOnly));

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            shadow <= '0;
            start  <= 1'b0;
        end else begin
            start <= launch;
            if (access && apbReq.pwrite) begin
                case (apbReq.paddr)
                    apbPkg::blockSize: shadow.blockSize <= apbReq.pwdata[15:0];
                    apbPkg::orders: begin
                        shadow.predictorOrder <= apbReq.pwdata[3:0];
                        shadow.partitionOrder <= apbReq.pwdata[7:4];
                    end
                    apbPkg::startBit:  shadow.startBit <= apbReq.pwdata[4:0];
                    apbPkg::startAddr: shadow.startAddr <= apbReq.pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    // job copy stays fixed while the engine runs.
    always_ff @(posedge iClock) begin
        if (launch) begin
            cfg <= shadow;
        end
    end

endmodule

//--- design/residualControl.sv
`timescale 1ns/1ps

module residualControl (
    input  logic               iClock,
    input  logic               rstN,
    input  logic               start,
    input  flacPkg::streamCfgT cfg,
    output logic               readParam,
    output logic               sampleEnable,
    input  logic               paramValid,
    input  logic [3:0]         param,
    input  logic               beatDone,
    output logic               busy,
    output logic               done,
    output logic               error,
    output logic [15:0]        sampleCount
);

    flacPkg::ctrlStateT state;
    logic [15:0]        partSize;
    logic [15:0]        lastPart;
    logic [15:0]        partIdx;
    logic [15:0]        samplesLeft;
    logic               sampleBusy;
    logic               partEnd;

    assign partSize = cfg.blockSize >> cfg.partitionOrder;
    assign lastPart = (16'd1 << cfg.partitionOrder) - 16'd1;
    assign busy     = state != flacPkg::idle;

    // one sample in flight at a time, so the parser never runs past a partition.
    assign sampleEnable = (state == flacPkg::samples) && !sampleBusy;

    assign partEnd = ((state == flacPkg::param) && paramValid &&
                      (param != flacPkg::ESCAPE_PARAM) && (samplesLeft == 16'd0)) ||
                     ((state == flacPkg::samples) && beatDone && (samplesLeft == 16'd1));

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            state       <= flacPkg::idle;
            readParam   <= 1'b0;
            sampleBusy  <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
            sampleCount <= '0;
        end else begin
            readParam <= 1'b0;
            if (beatDone) begin
                sampleBusy <= 1'b0;
            end else if (sampleEnable) begin
                sampleBusy <= 1'b1;
            end
            case (state)
                flacPkg::idle: begin
                    if (start) begin
                        state       <= flacPkg::prime;
                        done        <= 1'b0;
                        error       <= 1'b0;
                        sampleCount <= '0;
                    end
                end
                flacPkg::prime: begin
                    // warm-up samples are not coded in the first partition.
                    samplesLeft <= partSize - 16'(cfg.predictorOrder);
                    partIdx     <= '0;
                    readParam   <= 1'b1;
                    state       <= flacPkg::param;
                end
                flacPkg::param: begin
                    if (paramValid) begin
                        if (param == flacPkg::ESCAPE_PARAM) begin
                            state <= flacPkg::fault;
                        end else if (samplesLeft != 16'd0) begin
                            state <= flacPkg::samples;
                        end
                    end
                end
                flacPkg::samples: begin
                    if (beatDone) begin
                        samplesLeft <= samplesLeft - 16'd1;
                        sampleCount <= sampleCount + 16'd1;
                    end
                end
                flacPkg::finish: begin
                    done  <= 1'b1;
                    state <= flacPkg::idle;
                end
                flacPkg::fault: begin
                    error <= 1'b1;
                    state <= flacPkg::idle;
                end
                default: state <= flacPkg::idle;
            endcase
            if (partEnd) begin
                if (partIdx == lastPart) begin
                    state <= flacPkg::finish;
                end else begin
                    partIdx     <= partIdx + 16'd1;
                    samplesLeft <= partSize;
                    readParam   <= 1'b1;
                    state       <= flacPkg::param;
                end
            end
        end
    end

endmodule

//--- design/bitFetcher.sv
`timescale 1ns/1ps

module bitFetcher #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  iClock,
    input  logic                  rstN,
    input  logic                  start,
    input  flacPkg::streamCfgT    cfg,
    output logic [ADDR_WIDTH-1:0] memAddr,
    input  logic [DATA_WIDTH-1:0] memData,
    output logic                  dataBit,
    output logic                  bitValid,
    input  logic                  bitTake
);

    localparam int POS_W = $clog2(DATA_WIDTH);

    logic                  active;
    logic                  loading;
    logic [ADDR_WIDTH-1:0] addrReg;
    logic [DATA_WIDTH-1:0] shiftReg;
    logic [POS_W-1:0]      bitPos;

    // start address goes straight out so the first word arrives a cycle sooner.
    assign memAddr  = start ? ADDR_WIDTH'(cfg.startAddr) : addrReg;
    assign bitValid = active && !loading;
    assign dataBit  = shiftReg[DATA_WIDTH-1];

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            active  <= 1'b0;
            loading <= 1'b0;
        end else if (start) begin
            active  <= 1'b1;
            loading <= 1'b1;
            addrReg <= ADDR_WIDTH'(cfg.startAddr) + ADDR_WIDTH'(1);    // prefetch.
            bitPos  <= POS_W'(cfg.startBit);
        end else if (loading) begin
            shiftReg <= memData << bitPos;    // skip bits before the start.
            loading  <= 1'b0;
        end else if (bitValid && bitTake) begin
            shiftReg <= shiftReg << 1;
            bitPos   <= bitPos + 1'b1;    // wraps to 0 at the word end.
            if (bitPos == POS_W'(DATA_WIDTH - 1)) begin
                loading <= 1'b1;
                addrReg <= addrReg + ADDR_WIDTH'(1);
            end
        end
    end

endmodule

//--- design/riceFieldParser.sv
`timescale 1ns/1ps

module riceFieldParser #(
    parameter int DATA_WIDTH = 16
) (
    input  logic               iClock,
    input  logic               rstN,
    input  logic               dataBit,
    input  logic               bitValid,
    output logic               bitTake,
    input  logic               readParam,
    input  logic               sampleEnable,
    output logic               paramValid,
    output logic [3:0]         param,
    output flacPkg::riceFieldT field,
    output logic               fieldValid,
    input  logic               fieldTake
);

    typedef enum logic [2:0] {
        pIdle,
        pParam,
        pQuot,
        pRem,
        pHold
    } parseStateT;

    parseStateT            state;
    logic [3:0]            bitCount;
    logic [DATA_WIDTH-1:0] quotient;
    logic [DATA_WIDTH-1:0] remainder;

    assign bitTake = bitValid && ((state == pParam) || (state == pQuot) || (state == pRem));
    assign field   = '{quotient: 16'(quotient), remainder: 16'(remainder), param: param};

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            state      <= pIdle;
            paramValid <= 1'b0;
            fieldValid <= 1'b0;
        end else begin
            paramValid <= 1'b0;
            case (state)
                pIdle: begin
                    if (readParam) begin
                        bitCount <= '0;
                        state    <= pParam;
                    end else if (sampleEnable) begin
                        quotient  <= '0;
                        remainder <= '0;
                        state     <= pQuot;
                    end
                end
                pParam: begin
                    if (bitTake) begin
                        param    <= {param[2:0], dataBit};
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 4'd3) begin
                            paramValid <= 1'b1;
                            state      <= pIdle;
                        end
                    end
                end
                pQuot: begin
                    if (bitTake) begin
                        if (dataBit) begin    // stop bit of the unary part.
                            bitCount <= '0;
                            if (param == 4'd0) begin
                                fieldValid <= 1'b1;
                                state      <= pHold;
                            end else begin
                                state <= pRem;
                            end
                        end else begin
                            quotient <= quotient + 1'b1;
                        end
                    end
                end
                pRem: begin
                    if (bitTake) begin
                        remainder <= {remainder[DATA_WIDTH-2:0], dataBit};
                        bitCount  <= bitCount + 1'b1;
                        if (bitCount == param - 4'd1) begin
                            fieldValid <= 1'b1;
                            state      <= pHold;
                        end
                    end
                end
                pHold: begin
                    if (fieldTake) begin
                        fieldValid <= 1'b0;
                        state      <= pIdle;
                    end
                end
                default: state <= pIdle;
            endcase
        end
    end

endmodule

//--- design/riceValueDecoder.sv
`timescale 1ns/1ps

module riceValueDecoder #(
    parameter int DATA_WIDTH = 16
) (
    input  logic               iClock,
    input  logic               rstN,
    input  flacPkg::riceFieldT field,
    input  logic               fieldValid,
    output logic               fieldTake,
    output flacPkg::residualT  residual,
    input  logic               residualReady,
    output logic               beatDone
);

    logic [DATA_WIDTH-1:0] folded;
    logic [DATA_WIDTH-1:0] magnitude;
    logic [DATA_WIDTH-1:0] decoded;
    logic                  outValid;
    logic signed [15:0]    outValue;

    assign folded    = (DATA_WIDTH'(field.quotient) << field.param) |
                       DATA_WIDTH'(field.remainder);
    assign magnitude = folded >> 1;
    assign decoded   = folded[0] ? ~magnitude : magnitude;    // odd folds to -(v/2)-1.

    // refill the output register as it drains.
    assign fieldTake = fieldValid && (!outValid || residualReady);
    assign beatDone  = outValid && residualReady;
    assign residual  = '{valid: outValid, value: outValue};

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            if (fieldTake) begin
                outValid <= 1'b1;
                outValue <= 16'(decoded);
            end else if (residualReady) begin
                outValid <= 1'b0;
            end
        end
    end

endmodule

//--- design/residualDecoderTop.sv
`timescale 1ns/1ps

module residualDecoderTop #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 16
) (
    input  logic                  iClock,
    input  logic                  rstN,
    input  apbPkg::apbReqT        apbReq,
    output apbPkg::apbRspT        apbRsp,
    output logic [ADDR_WIDTH-1:0] memAddr,
    input  logic [DATA_WIDTH-1:0] memData,
    output flacPkg::residualT     residual,
    input  logic                  residualReady
);

    flacPkg::streamCfgT cfg;
    flacPkg::riceFieldT field;
    logic               start;
    logic               busy;
    logic               done;
    logic               error;
    logic [15:0]        sampleCount;
    logic               readParam;
    logic               sampleEnable;
    logic               paramValid;
    logic [3:0]         param;
    logic               dataBit;
    logic               bitValid;
    logic               bitTake;
    logic               fieldValid;
    logic               fieldTake;
    logic               beatDone;

    residualApbRegs regs (
        .iClock      (iClock),
        .rstN        (rstN),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .cfg         (cfg),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .error       (error),
        .sampleCount (sampleCount)
    );

    residualControl control (
        .iClock       (iClock),
        .rstN         (rstN),
        .start        (start),
        .cfg          (cfg),
        .readParam    (readParam),
        .sampleEnable (sampleEnable),
        .paramValid   (paramValid),
        .param        (param),
        .beatDone     (beatDone),
        .busy         (busy),
        .done         (done),
        .error        (error),
        .sampleCount  (sampleCount)
    );

    bitFetcher #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) fetcher (
        .iClock   (iClock),
        .rstN     (rstN),
        .start    (start),
        .cfg      (cfg),
        .memAddr  (memAddr),
        .memData  (memData),
        .dataBit  (dataBit),
        .bitValid (bitValid),
        .bitTake  (bitTake)
    );

    riceFieldParser #(
        .DATA_WIDTH (DATA_WIDTH)
    ) parser (
        .iClock       (iClock),
        .rstN         (rstN),
        .dataBit      (dataBit),
        .bitValid     (bitValid),
        .bitTake      (bitTake),
        .readParam    (readParam),
        .sampleEnable (sampleEnable),
        .paramValid   (paramValid),
        .param        (param),
        .field        (field),
        .fieldValid   (fieldValid),
        .fieldTake    (fieldTake)
    );

    riceValueDecoder #(
        .DATA_WIDTH (DATA_WIDTH)
    ) decoder (
        .iClock        (iClock),
        .rstN          (rstN),
        .field         (field),
        .fieldValid    (fieldValid),
        .fieldTake     (fieldTake),
        .residual      (residual),
        .residualReady (residualReady),
        .beatDone      (beatDone)
    );

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic iClock,
    output logic rstN
);

    initial begin
        iClock = 1'b0;
        forever #(PERIOD / 2) iClock = ~iClock;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge iClock);
        rstN <= 1'b1;    // released on an edge, seen as synchronous.
    end

endmodule

//--- dv/residualDecoder_checker.sv
`timescale 1ns/1ps

module residualDecoder_checker (
    input logic              iClock,
    input logic              rstN,
    input apbPkg::apbReqT    apbReq,
    input apbPkg::apbRspT    apbRsp,
    input flacPkg::residualT residual,
    input logic              residualReady,
    input logic              busy
);

    // a stalled beat must not move.
    holdWhileStalled: assert property (@(posedge iClock) disable iff (!rstN)
        residual.valid && !residualReady |=> residual.valid && $stable(residual.value))
        else $error("residual beat changed while residualReady was low");

    noWaitStates: assert property (@(posedge iClock) disable iff (!rstN)
        apbReq.psel && apbReq.penable |-> apbRsp.pready)
        else $error("pready low in an APB access cycle");

    idleAfterReset: assert property (@(posedge iClock)
        !rstN |=> !busy)
        else $error("busy set in the cycle after reset");

endmodule

bind residualDecoderTop residualDecoder_checker checks (
    .iClock        (iClock),
    .rstN          (rstN),
    .apbReq        (apbReq),
    .apbRsp        (apbRsp),
    .residual      (residual),
    .residualReady (residualReady),
    .busy          (busy)
);

//--- dv/residualTb.sv
`timescale 1ns/1ps

module residualTb;

    typedef struct packed {
        logic [15:0]     blockSize;
        logic [3:0]      predOrder;
        logic [3:0]      partOrder;
        logic [4:0]      startBit;
        logic [15:0]     startAddr;
        logic [7:0][3:0] params;      // partition 0 in the low nibble.
        logic [7:0]      limit;       // residuals within +-(limit << param).
        logic [7:0]      stallPct;
        logic            replay;      // reuse the previous row's residuals.
    } testRowT;

    localparam int          NUM_ROWS = 6;
    localparam logic [31:0] SEED     = 32'hb273_4df0;

    logic               iClock;
    logic               rstN;
    apbPkg::apbReqT     apbReq;
    apbPkg::apbRspT     apbRsp;
    logic [15:0]        memAddr;
    logic [15:0]        memData = '0;
    flacPkg::residualT  residual;
    logic               residualReady = 1'b0;

    logic [15:0]        ram [0:65535];
    testRowT            tbl [NUM_ROWS];
    string              rowName [NUM_ROWS];
    logic signed [15:0] expQ [$];
    logic signed [15:0] gotQ [$];
    logic [31:0]        dataState = SEED;
    logic [31:0]        stallState = SEED;
    logic [31:0]        rowSeed;
    int                 bitPtr;
    int                 stallPct = 0;
    logic               expError;
    int                 errorCount = 0;
    int                 testsRun = 0;
    int                 testsFailed = 0;

    clockGen #(
        .PERIOD       (100),
        .RESET_CYCLES (10)
    ) clocks (
        .iClock (iClock),
        .rstN   (rstN)
    );

    residualDecoderTop #(
        .DATA_WIDTH (16),
        .ADDR_WIDTH (16)
    ) dut (
        .iClock        (iClock),
        .rstN          (rstN),
        .apbReq        (apbReq),
        .apbRsp        (apbRsp),
        .memAddr       (memAddr),
        .memData       (memData),
        .residual      (residual),
        .residualReady (residualReady)
    );

    always @(posedge iClock) begin
        memData <= ram[memAddr];    // one-cycle read.
    end

    always @(posedge iClock) begin
        stallState = lcgNext(stallState);
        residualReady <= (stallState[31:16] % 16'd100) >= 16'(stallPct);
    end

    always @(posedge iClock) begin
        if (rstN && residual.valid && residualReady) begin
            gotQ.push_back(residual.value);
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int zigzag(input int r);
        return (r >= 0) ? 2 * r : -2 * r - 1;
    endfunction

    // worst case stream length of one row.
    function automatic int bitBound(input testRowT row);
        return int'(row.blockSize) * (2 * int'(row.limit) + 18) + 32;
    endfunction

    task automatic putBits(input int value, input int width);
        int pos;
        for (int i = width - 1; i >= 0; i--) begin
            pos = bitPtr;
            ram[pos >> 4][15 - (pos & 15)] = value[i];    // msb first in each word.
            bitPtr++;
        end
    endtask

    task automatic encodeRow(input testRowT row);
        int parts;
        int count;
        int p;
        int lim;
        int r;
        int fold;
        expQ.delete();
        expError = 1'b0;
        bitPtr = int'(row.startAddr) * 16 + int'(row.startBit);
        parts = 1 << row.partOrder;
        for (int k = 0; k < parts; k++) begin
            p = int'(row.params[k]);
            putBits(p, 4);
            if (p == 15) begin
                expError = 1'b1;
                break;
            end
            count = int'(row.blockSize >> row.partOrder);
            if (k == 0) begin
                count -= int'(row.predOrder);
            end
            lim = int'(row.limit) << p;
            for (int s = 0; s < count; s++) begin
                dataState = lcgNext(dataState);
                r = int'(dataState[31:16]) % (2 * lim) - lim;
                fold = zigzag(r);
                putBits(0, fold >> p);    // unary quotient.
                putBits(1, 1);
                putBits(fold, p);
                expQ.push_back(16'(r));
            end
        end
    endtask

    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge iClock);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge iClock);
        apbReq.penable <= 1'b1;
        @(negedge iClock);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge iClock);
        apbReq <= '0;
    endtask

    task automatic finishTest(input string name, input int errs, input int beats);
        testsRun++;
        errorCount += errs;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("test %-12s %s, %0d beats, %0d errors", name,
                 (errs == 0) ? "passed" : "FAILED", beats, errs);
    endtask

    task automatic checkRegisters();
        apbPkg::regAddrT addrs [4];
        logic [31:0]     vals [4];
        logic [31:0]     rd;
        logic            err;
        int              errs;
        addrs = '{apbPkg::blockSize, apbPkg::orders, apbPkg::startBit, apbPkg::startAddr};
        vals  = '{32'h0000_1234, 32'h0000_005a, 32'h0000_0013, 32'h0000_beef};
        errs  = 0;
        for (int i = 0; i < 4; i++) begin
            apbTransfer(1'b1, addrs[i], vals[i], rd, err);
            if (err) begin
                $display("write to offset %h gave an unexpected slave error", addrs[i]);
                errs++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            apbTransfer(1'b0, addrs[i], '0, rd, err);
            if (rd != vals[i]) begin
                $display("mismatch prdata at %h exp %h got %h", addrs[i], vals[i], rd);
                errs++;
            end
            if (err) begin
                $display("read of offset %h gave an unexpected slave error", addrs[i]);
                errs++;
            end
        end
        apbTransfer(1'b0, 8'h1c, '0, rd, err);
        if (!err) begin
            $display("read of unmapped offset 1c completed without a slave error");
            errs++;
        end
        apbTransfer(1'b1, apbPkg::status, 32'h7, rd, err);
        if (!err) begin
            $display("write to the status register completed without a slave error");
            errs++;
        end
        apbTransfer(1'b1, apbPkg::count, 32'h1, rd, err);
        if (!err) begin
            $display("write to the count register completed without a slave error");
            errs++;
        end
        finishTest("registers", errs, 0);
    endtask

    task automatic runRow(input int idx);
        testRowT     row;
        logic [31:0] rd;
        logic        err;
        int          polls;
        int          errs;
        row      = tbl[idx];
        errs     = 0;
        stallPct = int'(row.stallPct);
        if (!row.replay) begin
            rowSeed = dataState;
        end
        dataState = rowSeed;
        encodeRow(row);
        apbTransfer(1'b1, apbPkg::blockSize, 32'(row.blockSize), rd, err);
        apbTransfer(1'b1, apbPkg::orders, {24'b0, row.partOrder, row.predOrder}, rd, err);
        apbTransfer(1'b1, apbPkg::startBit, 32'(row.startBit), rd, err);
        apbTransfer(1'b1, apbPkg::startAddr, 32'(row.startAddr), rd, err);
        gotQ.delete();
        apbTransfer(1'b1, apbPkg::ctrl, 32'h1, rd, err);
        polls = 0;
        rd    = '0;
        while (!(rd[1] || rd[2]) && polls < bitBound(row) + 100) begin
            apbTransfer(1'b0, apbPkg::status, '0, rd, err);
            polls++;
        end
        if (!(rd[1] || rd[2])) begin
            $display("row %0d: engine never reported done or error", idx);
            errs++;
        end
        if (rd[2:1] != {expError, ~expError}) begin
            $display("mismatch status exp %h got %h", {expError, ~expError}, rd[2:1]);
            errs++;
        end
        if (gotQ.size() != expQ.size()) begin
            $display("mismatch beatCount exp %h got %h", expQ.size(), gotQ.size());
            errs++;
        end
        for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
            if (gotQ[i] !== expQ[i]) begin
                $display("mismatch residual[%0d] exp %h got %h", i, expQ[i], gotQ[i]);
                errs++;
            end
        end
        apbTransfer(1'b0, apbPkg::count, '0, rd, err);
        if (rd[15:0] != 16'(expQ.size())) begin
            $display("mismatch sampleCount exp %h got %h", 16'(expQ.size()), rd[15:0]);
            errs++;
        end
        finishTest(rowName[idx], errs, gotQ.size());
    endtask

    initial begin
        apbReq = '0;
        for (int a = 0; a < 65536; a++) begin
            ram[a] = 16'(a * 40503) ^ 16'h3c5a;    // background pattern.
        end
        rowName[0] = "single";
        tbl[0] = '{blockSize: 16'd32, predOrder: 4'd2, partOrder: 4'd0, startBit: 5'd0,
                   startAddr: 16'h0010, params: 32'h0000_0004, limit: 8'd3,
                   stallPct: 8'd0, replay: 1'b0};
        rowName[1] = "partitions";
        tbl[1] = '{blockSize: 16'd64, predOrder: 4'd4, partOrder: 4'd2, startBit: 5'd0,
                   startAddr: 16'h0100, params: 32'h0000_1503, limit: 8'd3,
                   stallPct: 8'd0, replay: 1'b0};
        rowName[2] = "aligned";
        tbl[2] = '{blockSize: 16'd48, predOrder: 4'd1, partOrder: 4'd1, startBit: 5'd0,
                   startAddr: 16'h0200, params: 32'h0000_0027, limit: 8'd2,
                   stallPct: 8'd0, replay: 1'b0};
        rowName[3] = "unaligned";
        tbl[3] = '{blockSize: 16'd48, predOrder: 4'd1, partOrder: 4'd1, startBit: 5'd11,
                   startAddr: 16'h0345, params: 32'h0000_0027, limit: 8'd2,
                   stallPct: 8'd0, replay: 1'b1};
        rowName[4] = "backpressure";
        tbl[4] = '{blockSize: 16'd64, predOrder: 4'd2, partOrder: 4'd3, startBit: 5'd5,
                   startAddr: 16'h0400, params: 32'h8341_9062, limit: 8'd3,
                   stallPct: 8'd50, replay: 1'b0};
        rowName[5] = "escape";
        tbl[5] = '{blockSize: 16'd32, predOrder: 4'd0, partOrder: 4'd2, startBit: 5'd3,
                   startAddr: 16'h0600, params: 32'h0000_4f25, limit: 8'd3,
                   stallPct: 8'd25, replay: 1'b0};
        wait (rstN === 1'b1);
        repeat (2) @(posedge iClock);
        checkRegisters();
        for (int i = 0; i < NUM_ROWS; i++) begin
            runRow(i);
        end
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // four cycles per stream bit plus room for register traffic.
    initial begin
        int budget;
        budget = 3000;
        wait (rstN === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            budget += 4 * bitBound(tbl[i]);
        end
        repeat (budget) @(posedge iClock);
        $display("timeout: the run did not finish within %0d cycles", budget);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- sim.f
design/flacPkg.sv
design/apbPkg.sv
design/residualApbRegs.sv
design/residualControl.sv
design/bitFetcher.sv
design/riceFieldParser.sv
design/riceValueDecoder.sv
design/residualDecoderTop.sv
dv/clockGen.sv
dv/residualDecoder_checker.sv
dv/residualTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= residualTb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Finished with errors
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
